/* common/fetch_pkg.sv */
package fetch_pkg;

	// Number of external interrupt request lines
	localparam int IRQ_COUNT = 4;

	// Major opcodes seen by the predecoder
	localparam logic [6:0] OPCODE_JAL = 7'b1101111;
	localparam logic [6:0] OPCODE_JALR = 7'b1100111;
	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
	localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

	// SYSTEM instructions with funct3 zero are told apart by imm12
	localparam logic [2:0] FUNCT3_PRIV = 3'b000;
	localparam logic [11:0] FUNCT12_ECALL = 12'h000;
	localparam logic [11:0] FUNCT12_WFI = 12'h105;
	localparam logic [11:0] FUNCT12_MRET = 12'h302;

	// One item handed to decode, a new tag marks a new item
	typedef struct packed {
		logic [3:0] tag;
		logic [31:0] pc;
		logic [31:0] instruction;
	} fetch_data_t;

	// I-type layout, MSB first
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} itype_fields_t;

	// Same instruction word, seen whole or split into I-type fields
	typedef union packed {
		logic [31:0] raw;
		itype_fields_t itype;
	} instr_word_u;

endpackage

/* icache/icache.sv */
`timescale 1ns/1ps

module icache #(
	parameter int ICACHE_LINES = 16
)(
	input logic i_clock,
	input logic i_reset,

	// Lookup from the sequencer
	input logic [31:0] i_pc,
	input logic i_stall,
	output logic [31:0] o_rdata,
	output logic o_ready,

	// Refill bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(ICACHE_LINES);
	localparam int TAG_BITS = 30 - INDEX_BITS;

	typedef enum logic {
		LOOKUP,
		REFILL
	} state_t;

	state_t state;

	logic [ICACHE_LINES-1:0] valid;
	logic [TAG_BITS-1:0] tag_array [ICACHE_LINES];
	logic [31:0] data_array [ICACHE_LINES];

	logic [INDEX_BITS-1:0] pc_index;
	logic [TAG_BITS-1:0] pc_tag;
	logic [INDEX_BITS-1:0] refill_index;
	logic [TAG_BITS-1:0] refill_tag;
	logic hit;
	logic lookup;
	logic refill_done;

	// Word address split into line index and tag
	assign pc_index = i_pc[INDEX_BITS+1:2];
	assign pc_tag = i_pc[31:INDEX_BITS+2];
	assign refill_index = o_bus_address[INDEX_BITS+1:2];
	assign refill_tag = o_bus_address[31:INDEX_BITS+2];

	assign hit = valid[pc_index] && (tag_array[pc_index] == pc_tag);

	// No lookup in the cycle a word is handed over, the PC moves on then
	assign lookup = (state == LOOKUP) && !i_stall && !o_ready;
	assign refill_done = (state == REFILL) && i_bus_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= LOOKUP;
			valid <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
		end
		else begin
			o_ready <= 1'b0;
			case (state)
				LOOKUP: begin
					if (lookup) begin
						if (hit) begin
							o_ready <= 1'b1;
						end
						else begin
							o_bus_request <= 1'b1;
							state <= REFILL;
						end
					end
				end

				REFILL: begin
					if (i_bus_ready) begin
						valid[refill_index] <= 1'b1;
						o_bus_request <= 1'b0;
						// Word is kept either way, only handed over if still wanted
						o_ready <= !i_stall && (i_pc[31:2] == o_bus_address[31:2]);
						state <= LOOKUP;
					end
				end

				default: begin
					state <= LOOKUP;
				end
			endcase
		end
	end

	// Arrays, read data and refill address
	always_ff @(posedge i_clock) begin
		if (lookup && hit) begin
			o_rdata <= data_array[pc_index];
		end
		if (lookup && !hit) begin
			o_bus_address <= {i_pc[31:2], 2'b00};
		end
		if (refill_done) begin
			tag_array[refill_index] <= refill_tag;
			data_array[refill_index] <= i_bus_rdata;
			o_rdata <= i_bus_rdata;
		end
	end

endmodule

/* design/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller import fetch_pkg::*; #(
	parameter logic [31:0] IRQ_BASE = 32'h0000_0100
)(
	input logic i_clock,
	input logic i_reset,

	input logic [IRQ_COUNT-1:0] i_irq_lines,

	// Handshake with the sequencer
	input logic i_dispatched,
	output logic o_pending,
	output logic [31:0] o_handler_pc
);

	localparam int ID_BITS = $clog2(IRQ_COUNT);

	// Handlers are spaced 16 bytes apart
	localparam int HANDLER_SHIFT = 4;

	logic [IRQ_COUNT-1:0] lines_q;
	logic [IRQ_COUNT-1:0] latched;
	logic [IRQ_COUNT-1:0] rising;
	logic [IRQ_COUNT-1:0] select_onehot;
	logic [IRQ_COUNT-1:0] clear_mask;
	logic [ID_BITS-1:0] select_id;

	assign rising = i_irq_lines & ~lines_q;

	// Lowest numbered source wins
	always_comb begin
		select_id = '0;
		for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
			if (latched[i]) begin
				select_id = ID_BITS'(i);
			end
		end
	end

	assign select_onehot = IRQ_COUNT'(1) << select_id;
	assign clear_mask = i_dispatched ? select_onehot : '0;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			lines_q <= '0;
			latched <= '0;
		end
		else begin
			lines_q <= i_irq_lines;
			// A new request on the cleared source survives the clear
			latched <= (latched & ~clear_mask) | rising;
		end
	end

	assign o_pending = |latched;
	assign o_handler_pc = IRQ_BASE + (32'(select_id) << HANDLER_SHIFT);

endmodule

/* design/fetch_sequencer.sv */
`timescale 1ns/1ps

module fetch_sequencer import fetch_pkg::*; #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
)(
	input logic i_clock,
	input logic i_reset,

	// Jump target from the pipeline
	input logic i_jump,
	input logic [31:0] i_jump_pc,

	// Interrupt controller
	input logic i_irq_pending,
	input logic [31:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	// Instruction cache
	output logic [31:0] o_pc,
	output logic o_stall,
	input logic [31:0] i_rdata,
	input logic i_ready,

	// Decode stage
	input logic i_decode_busy,
	output fetch_data_t o_data
);

	typedef enum logic [1:0] {
		FETCH,
		WAIT_JUMP,
		WAIT_IRQ
	} state_t;

	state_t state;
	logic [31:0] pc;
	fetch_data_t data;
	instr_word_u word;

	logic is_system;
	logic is_jump;
	logic is_wait;
	logic take_irq;
	logic accept;

	// Predecode of the word coming out of the cache
	assign word.raw = i_rdata;

	assign is_system = (word.itype.opcode == OPCODE_SYSTEM)
		&& (word.itype.funct3 == FUNCT3_PRIV);

	// Anything that redirects the PC waits for the pipeline target
	assign is_jump = (word.itype.opcode == OPCODE_JAL)
		|| (word.itype.opcode == OPCODE_JALR)
		|| (word.itype.opcode == OPCODE_BRANCH)
		|| (is_system && (word.itype.imm12 == FUNCT12_MRET));

	assign is_wait = is_system
		&& ((word.itype.imm12 == FUNCT12_ECALL) || (word.itype.imm12 == FUNCT12_WFI));

	// Interrupts go in only between instructions
	assign take_irq = (state == FETCH) && i_irq_pending && !o_irq_dispatched;

	// A word offered while decode is busy is dropped and looked up again later
	assign accept = i_ready && !i_decode_busy;

	// Also hold the cache in the dispatch cycle, the PC is about to move
	assign o_stall = i_decode_busy || (state != FETCH) || take_irq;

	assign o_pc = pc;
	assign o_data = data;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH;
			pc <= RESET_VECTOR;
			data <= '0;
			o_irq_dispatched <= 1'b0;
			o_irq_epc <= '0;
		end
		else begin
			o_irq_dispatched <= 1'b0;
			case (state)
				FETCH: begin
					if (take_irq) begin
						// Return to the first word not yet delivered
						o_irq_dispatched <= 1'b1;
						o_irq_epc <= pc;
						pc <= i_irq_pc;
					end
					else if (accept) begin
						data.tag <= data.tag + 4'd1;
						data.pc <= pc;
						data.instruction <= word.raw;
						if (is_jump) begin
							state <= WAIT_JUMP;
						end
						else if (is_wait) begin
							state <= WAIT_IRQ;
						end
						else begin
							pc <= pc + 32'd4;
						end
					end
				end

				WAIT_JUMP: begin
					if (i_jump) begin
						pc <= i_jump_pc;
						state <= FETCH;
					end
				end

				WAIT_IRQ: begin
					// PC still points at the ECALL or WFI itself
					if (i_irq_pending && !o_irq_dispatched) begin
						o_irq_dispatched <= 1'b1;
						o_irq_epc <= pc + 32'd4;
						pc <= i_irq_pc;
						state <= FETCH;
					end
				end

				default: begin
					state <= FETCH;
				end
			endcase
		end
	end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
	parameter int ICACHE_LINES = 16,
	parameter logic [31:0] IRQ_BASE = 32'h0000_0100
)(
	input logic i_clock,
	input logic i_reset,

	// Pipeline control
	input logic i_jump,
	input logic [31:0] i_jump_pc,

	// Interrupts
	input logic [IRQ_COUNT-1:0] i_irq_lines,
	output logic o_irq_dispatched,
	output logic [31:0] o_irq_epc,

	// Memory bus
	output logic o_bus_request,
	input logic i_bus_ready,
	output logic [31:0] o_bus_address,
	input logic [31:0] i_bus_rdata,

	// Decode stage
	input logic i_decode_busy,
	output fetch_data_t o_data
);

	logic [31:0] fetch_pc;
	logic fetch_stall;
	logic [31:0] cache_rdata;
	logic cache_ready;
	logic irq_pending;
	logic [31:0] irq_pc;

	icache #(
		.ICACHE_LINES(ICACHE_LINES)
	) icache0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(fetch_pc),
		.i_stall(fetch_stall),
		.o_rdata(cache_rdata),
		.o_ready(cache_ready),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata)
	);

	irq_controller #(
		.IRQ_BASE(IRQ_BASE)
	) irq0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_irq_lines(i_irq_lines),
		.i_dispatched(o_irq_dispatched),
		.o_pending(irq_pending),
		.o_handler_pc(irq_pc)
	);

	fetch_sequencer #(
		.RESET_VECTOR(RESET_VECTOR)
	) sequencer0 (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(irq_pending),
		.i_irq_pc(irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_pc(fetch_pc),
		.o_stall(fetch_stall),
		.i_rdata(cache_rdata),
		.i_ready(cache_ready),
		.i_decode_busy(i_decode_busy),
		.o_data(o_data)
	);

endmodule

/* testbench/fetch_assert.sv */
`timescale 1ns/1ps

module fetch_assert import fetch_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic o_irq_dispatched,
	input logic o_bus_request,
	input logic i_bus_ready,
	input logic [31:0] o_bus_address,
	input logic i_decode_busy,
	input fetch_data_t o_data
);

	// Read by the testbench for its closing count
	int unsigned failures = 0;

	// Reset values of the outputs
	reset_state: assert property (@(posedge i_clock)
		i_reset |=> (!o_bus_request && !o_irq_dispatched && (o_data == '0)))
		else begin
			$error("outputs not cleared by reset");
			failures++;
		end

	// Dispatch is a single-cycle pulse
	dispatch_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		o_irq_dispatched |=> !o_irq_dispatched)
		else begin
			$error("interrupt dispatch pulse longer than one cycle");
			failures++;
		end

	// Request and address held until the bus answers
	bus_steady: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_address)))
		else begin
			$error("bus request dropped or address moved before ready");
			failures++;
		end

	// No new item while decode is busy
	busy_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		i_decode_busy |=> $stable(o_data.tag))
		else begin
			$error("tag changed while decode was busy");
			failures++;
		end

	tag_step: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_data.tag != $past(o_data.tag)) |-> (o_data.tag == $past(o_data.tag) + 4'd1))
		else begin
			$error("tag did not advance by one");
			failures++;
		end

endmodule

bind fetch_top fetch_assert assert0 (.*);

/* testbench/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

	localparam int CLOCK_PERIOD = 4;
	localparam int MAX_CYCLES = 2000;
	localparam logic [31:0] IRQ_BASE = 32'd256;

	// Program layout
	localparam logic [31:0] LOOP_START = 32'd8;
	localparam logic [31:0] LOOP_BRANCH = 32'd16;
	localparam logic [31:0] ECALL_PC = 32'd24;
	localparam logic [31:0] ASYNC_PC = 32'd40;
	localparam logic [31:0] END_PC = 32'd72;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	logic [31:0] i_jump_pc;
	logic [IRQ_COUNT-1:0] i_irq_lines;
	logic o_irq_dispatched;
	logic [31:0] o_irq_epc;
	logic o_bus_request;
	logic i_bus_ready;
	logic [31:0] o_bus_address;
	logic [31:0] i_bus_rdata;
	logic i_decode_busy;
	fetch_data_t o_data;

	logic [31:0] program_mem [0:127];
	logic [127:0] refilled;
	int seed = 63925;
	int errors = 0;
	int bus_delay = 0;
	logic bus_serving = 1'b0;

	// Mirror of the fetch stream
	logic [3:0] last_tag = '0;
	logic [31:0] expected_pc = 32'd0;
	logic [31:0] epc_stack [$];
	logic [31:0] wait_pc = 32'd0;
	logic [31:0] jump_target = 32'd0;
	logic [IRQ_COUNT-1:0] pending_model = '0;
	logic waiting_irq = 1'b0;
	logic in_loop = 1'b0;
	logic async_sent = 1'b0;
	logic done = 1'b0;
	int jump_delay = 0;
	int loop_passes = 0;
	int dispatch_count = 0;

	fetch_top #(
		.RESET_VECTOR(32'd0),
		.ICACHE_LINES(16),
		.IRQ_BASE(IRQ_BASE)
	) dut0 (.*);

	function automatic logic [31:0] system_word(input logic [11:0] funct12);
		return {funct12, 5'd0, FUNCT3_PRIV, 5'd0, OPCODE_SYSTEM};
	endfunction

	function automatic logic redirects(input logic [31:0] w);
		return (w[6:0] == OPCODE_JAL) || (w[6:0] == OPCODE_JALR)
			|| (w[6:0] == OPCODE_BRANCH) || (w == system_word(FUNCT12_MRET));
	endfunction

	function automatic logic waits_for_irq(input logic [31:0] w);
		return (w == system_word(FUNCT12_ECALL)) || (w == system_word(FUNCT12_WFI));
	endfunction

	function automatic int lowest_pending(input logic [IRQ_COUNT-1:0] mask);
		int n;
		n = -1;
		for (int i = 0; i < IRQ_COUNT; i++) begin
			if (mask[i] && n < 0) begin
				n = i;
			end
		end
		return n;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// Fill words are ADDI x1 with the word address as immediate
	initial begin
		for (int i = 0; i < 128; i++) begin
			program_mem[i] = {12'(i), 5'd0, 3'b000, 5'd1, 7'b0010011};
		end
		// BNE x1, x2, -8
		program_mem[4] = {1'b1, 6'b111111, 5'd2, 5'd1, 3'b001, 4'b1100, 1'b1, OPCODE_BRANCH};
		program_mem[6] = system_word(FUNCT12_ECALL);
		program_mem[8] = system_word(FUNCT12_WFI);
		program_mem[18] = {20'd0, 5'd0, OPCODE_JAL};
		// Handler n starts at IRQ_BASE + 16n and returns with MRET
		for (int n = 0; n < IRQ_COUNT; n++) begin
			program_mem[65 + 4 * n] = system_word(FUNCT12_MRET);
		end
	end

	initial begin
		i_clock = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2) i_clock = ~i_clock;
		end
	end

	initial begin
		i_reset <= 1'b1;
		i_jump <= 1'b0;
		i_jump_pc <= '0;
		i_irq_lines <= '0;
		i_bus_ready <= 1'b0;
		i_bus_rdata <= '0;
		i_decode_busy <= 1'b0;
		refilled = '0;
		repeat (5) @(posedge i_clock);
		i_reset <= 1'b0;
		wait (done);
		repeat (4) @(posedge i_clock);
		if (loop_passes != 3 || dispatch_count != 4) begin
			$display("program finished without three loop passes and four interrupts");
			errors++;
		end
		$display("errors: %0d (mirror checks %0d, assertions %0d)",
			errors + int'(dut0.assert0.failures), errors, dut0.assert0.failures);
		if (errors == 0 && dut0.assert0.failures == 0) begin
			$display("*** PASSED ***");
		end
		else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(MAX_CYCLES * CLOCK_PERIOD);
		$display("timeout: program end not reached within %0d cycles", MAX_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	// Memory answers after 1 to 4 cycles
	task automatic serve_bus();
		i_bus_ready <= 1'b0;
		if (!i_reset && o_bus_request && !i_bus_ready) begin
			if (!bus_serving) begin
				bus_serving = 1'b1;
				bus_delay = 1 + int'({$random(seed)} % 4);
				if (in_loop && o_bus_address >= LOOP_START && o_bus_address <= LOOP_BRANCH
					&& refilled[o_bus_address[8:2]]) begin
					$display("bus request at %0t for cached loop address %h",
						$time, o_bus_address);
					errors++;
				end
			end
			bus_delay--;
			if (bus_delay == 0) begin
				bus_serving = 1'b0;
				refilled[o_bus_address[8:2]] = 1'b1;
				i_bus_ready <= 1'b1;
				i_bus_rdata <= program_mem[o_bus_address[8:2]];
			end
		end
	endtask

	task automatic track_item();
		logic [31:0] pc;
		logic [31:0] w;
		pc = o_data.pc;
		w = o_data.instruction;
		compare("o_data.instruction", program_mem[pc[8:2]], w);
		compare("o_data.pc", expected_pc, pc);
		if (pc == END_PC) begin
			done = 1'b1;
		end
		else if (redirects(w)) begin
			if (pc == LOOP_BRANCH) begin
				loop_passes++;
				in_loop = loop_passes < 3;
				jump_target = in_loop ? LOOP_START : pc + 32'd4;
			end
			else if (w == system_word(FUNCT12_MRET)) begin
				// Innermost interrupt returns first
				if (epc_stack.size() == 0) begin
					$display("MRET at %0t with no interrupt to return from", $time);
					errors++;
					jump_target = pc + 32'd4;
				end
				else begin
					jump_target = epc_stack.pop_back();
				end
			end
			else begin
				jump_target = pc + 32'd4;
			end
			jump_delay = 1 + int'({$random(seed)} % 3);
		end
		else if (waits_for_irq(w)) begin
			waiting_irq = 1'b1;
			wait_pc = pc;
			// ECALL gets one source, WFI two at once
			if (pc == ECALL_PC) begin
				pending_model = pending_model | 4'b0100;
				i_irq_lines <= 4'b0100;
			end
			else begin
				pending_model = pending_model | 4'b1010;
				i_irq_lines <= 4'b1010;
			end
		end
		else begin
			expected_pc = pc + 32'd4;
			if (pc == ASYNC_PC && !async_sent) begin
				async_sent = 1'b1;
				pending_model = pending_model | 4'b0001;
				i_irq_lines <= 4'b0001;
			end
		end
	endtask

	task automatic verify_dispatch();
		int n;
		logic [31:0] epc;
		n = lowest_pending(pending_model);
		epc = waiting_irq ? wait_pc + 32'd4 : expected_pc;
		dispatch_count++;
		compare("o_irq_epc", epc, o_irq_epc);
		epc_stack.push_back(epc);
		waiting_irq = 1'b0;
		if (n < 0) begin
			$display("interrupt dispatched at %0t with no line raised", $time);
			errors++;
		end
		else begin
			pending_model[n] = 1'b0;
			expected_pc = IRQ_BASE + 32'(16 * n);
		end
	endtask

	// Bus model, decode stalls, stream monitor, jump answers and interrupt lines
	always @(posedge i_clock) begin
		serve_bus();
		if (!i_reset) begin
			i_decode_busy <= ({$random(seed)} % 4) == 0;
			i_jump <= 1'b0;
			i_irq_lines <= '0;
			if (jump_delay > 0) begin
				jump_delay--;
				if (jump_delay == 0) begin
					i_jump <= 1'b1;
					i_jump_pc <= jump_target;
					expected_pc = jump_target;
				end
			end
			if (o_data.tag != last_tag) begin
				last_tag = o_data.tag;
				track_item();
			end
			if (o_irq_dispatched) begin
				verify_dispatch();
			end
		end
	end

endmodule

/* fetch_unit.f */
common/fetch_pkg.sv
icache/icache.sv
design/irq_controller.sv
design/fetch_sequencer.sv
design/fetch_top.sv
testbench/fetch_assert.sv
testbench/tb_fetch.sv

/* Makefile */
TOP = tb_fetch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f fetch_unit.f

run: compile
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
